/* ex_vectors.txt */
# class f3 rd rs1 rs2 pc src_a src_b imm mem_w mem_rd mem_data wb_w wb_rd wb_data
# hold flush exp_result exp_store_data exp_pc_update exp_dnpc (all hex)
8 0 5 1 2 1000 5 7 0 0 0 0 0 0 0 0 0 c 7 0 0
8 0 5 1 2 1000 5 7 400 0 0 0 0 0 0 0 0 fffffffffffffffe 7 0 0
8 7 5 1 2 1000 f0f0 ff00 0 0 0 0 0 0 0 0 0 f000 ff00 0 0
8 6 5 1 2 1000 f0f0 ff00 0 0 0 0 0 0 0 0 0 fff0 ff00 0 0
8 4 5 1 2 1000 f0f0 ff00 0 0 0 0 0 0 0 0 0 ff0 ff00 0 0
8 2 5 1 2 1000 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 1 1 0 0
8 3 5 1 2 1000 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 1 0 0
8 1 5 1 2 1000 1 44 0 0 0 0 0 0 0 0 0 10 44 0 0
8 5 5 1 2 1000 8000000000000000 3f 0 0 0 0 0 0 0 0 0 1 3f 0 0
8 5 5 1 2 1000 8000000000000000 3f 400 0 0 0 0 0 0 0 0 ffffffffffffffff 3f 0 0
7 0 5 1 2 1000 10 0 fffffffffffffff0 0 0 0 0 0 0 0 0 0 0 0 0
7 1 5 1 2 1000 3 0 3f 0 0 0 0 0 0 0 0 8000000000000000 0 0 0
a 0 5 1 2 1000 7fffffff 1 0 0 0 0 0 0 0 0 0 ffffffff80000000 1 0 0
a 0 5 1 2 1000 0 1 400 0 0 0 0 0 0 0 0 ffffffffffffffff 1 0 0
a 1 5 1 2 1000 1 3f 0 0 0 0 0 0 0 0 0 ffffffff80000000 3f 0 0
a 5 5 1 2 1000 ffffffff80000000 4 0 0 0 0 0 0 0 0 0 8000000 4 0 0
a 5 5 1 2 1000 ffffffff80000000 4 400 0 0 0 0 0 0 0 0 fffffffff8000000 4 0 0
9 5 5 1 2 1000 10 0 1 0 0 0 0 0 0 0 0 8 0 0 0
9 0 5 1 2 1000 ffffffff 0 1 0 0 0 0 0 0 0 0 0 0 0 0
0 0 5 1 2 1000 0 0 12345000 0 0 0 0 0 0 0 0 12345000 0 0 0
1 0 5 1 2 1000 0 0 2000 0 0 0 0 0 0 0 0 3000 0 0 0
2 0 5 1 2 1000 0 0 80 0 0 0 0 0 0 0 0 1004 0 0 0
5 3 5 1 2 1000 100 0 8 0 0 0 0 0 0 0 0 108 0 0 0
6 3 5 1 2 1000 200 dead 10 0 0 0 0 0 0 0 0 210 dead 0 0
8 0 5 1 2 1000 5 7 0 1 1 100 1 1 200 0 0 107 7 0 0
8 0 5 1 2 1000 5 7 0 1 2 30 1 1 20 0 0 50 30 0 0
8 0 5 0 2 1000 5 7 0 1 0 99 1 0 88 0 0 c 7 0 0
7 0 5 1 2 1000 5 7 1 1 2 99 0 0 0 0 0 6 7 0 0
4 0 5 1 2 1000 5 5 20 0 0 0 0 0 0 0 0 0 5 1 1020
4 1 5 1 2 1000 5 5 20 0 0 0 0 0 0 0 0 0 5 0 0
4 4 5 1 2 1000 ffffffffffffffff 1 fffffffffffffff0 0 0 0 0 0 0 0 0 fffffffffffffffe 1 0 0
4 5 5 1 2 1000 ffffffffffffffff 1 fffffffffffffff0 0 0 0 0 0 0 0 0 fffffffffffffffe 1 1 1004
4 6 5 1 2 1000 ffffffffffffffff 1 20 0 0 0 0 0 0 0 0 fffffffffffffffe 1 0 0
4 7 5 1 2 1000 ffffffffffffffff 1 20 0 0 0 0 0 0 0 0 fffffffffffffffe 1 1 1020
3 0 5 1 2 1000 4000 0 8 0 0 0 0 0 0 0 0 1004 0 1 4008
8 0 5 1 2 1000 3 ffffffffffffffff 20 0 0 0 0 0 0 0 0 fffffffffffffffd ffffffffffffffff 0 0
8 0 5 1 2 1000 100000001 100000001 20 0 0 0 0 0 0 0 0 200000001 100000001 0 0
a 0 5 1 2 1000 40000000 2 20 0 0 0 0 0 0 0 0 ffffffff80000000 2 0 0
8 0 5 1 2 1000 6 7 20 0 0 0 0 0 0 3 0 2a 7 0 0
4 0 5 1 2 1000 1 1 40 0 0 0 0 0 0 4 0 0 1 1 1040
8 0 5 1 2 1000 5 7 0 0 0 0 0 0 0 0 1 0 0 0 0

/* ex_stage.f */
+incdir+.
ex_pkg.sv
ex_issue_reg.sv
operand_bypass.sv
alu_core.sv
branch_resolve.sv
shift_add_mul.sv
ex_stage.sv
ex_stage_properties.sv
tb_ex_stage.sv

/* run.sh */
#!/bin/sh
# build and run the ex_stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ex_stage -f ex_stage.f -o sim_ex_stage

./obj_dir/sim_ex_stage > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi

/* tb_ex_stage.sv */
`timescale 1ns/1ps
`include "ex_settings.svh"

module tb_ex_stage import ex_pkg::*; ();

    localparam int MAX_VEC = 64;

    logic      clk;
    logic      rst;
    logic      flush;
    logic      in_valid;
    id_ex_t    in_instr;
    logic      in_ready;
    fwd_t      mem_fwd;
    fwd_t      wb_fwd;
    logic      out_valid;
    logic      out_ready;
    ex_mem_t   out_data;
    redirect_t redirect;

    // vector storage, filled before the run starts
    id_ex_t    v_instr [MAX_VEC];
    fwd_t      v_mem [MAX_VEC];
    fwd_t      v_wb [MAX_VEC];
    int        v_hold [MAX_VEC];
    logic      v_flush [MAX_VEC];
    xword_t    v_result [MAX_VEC];
    xword_t    v_store [MAX_VEC];
    redirect_t v_redir [MAX_VEC];
    int        n_vec = 0;
    int        test_errs;
    int        fail_tests = 0;
    int        total_errs = 0;

    ex_stage DUT (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_ready  (in_ready),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .redirect  (redirect)
    );

    // 100 ns period
    always #50 clk = ~clk;

    task automatic check_word(input string name, input xword_t got, input xword_t exp);
        if (got !== exp) begin
            $display("ERR %s got=%h exp=%h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got=%h exp=%h", name, got, exp);
            test_errs++;
        end
    endtask

    // target only matters when a redirect is expected
    task automatic check_redirect(input redirect_t got, input redirect_t exp);
        check_flag("redirect.pc_update", got.pc_update, exp.pc_update);
        if (exp.pc_update) begin
            check_word("redirect.dnpc", got.dnpc, exp.dnpc);
        end
    endtask

    // fields carried straight through from the issued instruction
    task automatic check_tags(input ex_mem_t got, input id_ex_t exp);
        check_word("out_data.pc", got.pc, exp.pc);
        if (got.op_class !== exp.op_class || got.funct3 !== exp.funct3
                || got.rd !== exp.rd || got.rs2 !== exp.rs2) begin
            $display("ERR out_data.{op_class,funct3,rd,rs2} got=%h exp=%h",
                     {got.op_class, got.funct3, got.rd, got.rs2},
                     {exp.op_class, exp.funct3, exp.rd, exp.rs2});
            test_errs++;
        end
    endtask

    // columns: class f3 rd rs1 rs2 pc src_a src_b imm mem(w rd data) wb(w rd data)
    // hold flush result store_data pc_update dnpc
    task automatic load_vectors();
        int     fd;
        int     cnt;
        string  line;
        xword_t f [21];
        fd = $fopen("ex_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open ex_vectors.txt");
            return;
        end
        while (!$feof(fd) && n_vec < MAX_VEC) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 4 || line[0] == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                          f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
            if (cnt != 21) begin
                $display("malformed vector line skipped: %s", line);
                total_errs++;
                continue;
            end
            v_instr[n_vec] = '{pc: f[5], op_class: op_class_e'(f[0][3:0]), funct3: f[1][2:0],
                               rd: f[2][4:0], rs1: f[3][4:0], rs2: f[4][4:0],
                               src_a: f[6], src_b: f[7], imm: f[8]};
            v_mem[n_vec]    = '{writing: f[9][0], rd: f[10][4:0], data: f[11]};
            v_wb[n_vec]     = '{writing: f[12][0], rd: f[13][4:0], data: f[14]};
            v_hold[n_vec]   = int'(f[15]);
            v_flush[n_vec]  = f[16][0];
            v_result[n_vec] = f[17];
            v_store[n_vec]  = f[18];
            v_redir[n_vec]  = '{pc_update: f[19][0], dnpc: f[20]};
            n_vec++;
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input int i);
        test_errs = 0;
        @(posedge clk);
        in_valid  <= 1'b1;
        in_instr  <= v_instr[i];
        mem_fwd   <= v_mem[i];
        wb_fwd    <= v_wb[i];
        out_ready <= 1'b1;
        // accepted on this edge
        @(posedge clk);
        in_valid  <= 1'b0;
        // a stalled register must not pick this up
        in_instr  <= '0;
        out_ready <= (v_hold[i] > 0 || v_flush[i]) ? 1'b0 : 1'b1;
        flush     <= v_flush[i];
        if (v_flush[i]) begin
            @(posedge clk);
            flush     <= 1'b0;
            out_ready <= 1'b1;
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
        end else begin
            // back-pressure, no redirect may leak out
            repeat (v_hold[i]) begin
                @(negedge clk);
                check_flag("redirect.pc_update", redirect.pc_update, 1'b0);
                @(posedge clk);
            end
            out_ready <= 1'b1;
            @(negedge clk);
            while (!out_valid) begin
                check_flag("in_ready", in_ready, 1'b0);
                @(negedge clk);
            end
            check_word("out_data.result", out_data.result, v_result[i]);
            check_word("out_data.store_data", out_data.store_data, v_store[i]);
            check_tags(out_data, v_instr[i]);
            check_redirect(redirect, v_redir[i]);
            @(posedge clk);
        end
        if (test_errs == 0) begin
            $display("test %0d ok", i);
        end else begin
            $display("test %0d FAILED with %0d mismatches", i, test_errs);
            fail_tests++;
            total_errs += test_errs;
        end
    endtask

    // each test gets room for a full multiply plus handshakes
    initial begin
        wait (n_vec > 0);
        #(n_vec * (`MUL_ITER_D + 20) * 100 + 1000);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        mem_fwd   = '0;
        wb_fwd    = '0;
        out_ready = 1'b0;
        load_vectors();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_vec; i++) begin
            run_vector(i);
        end
        $display("%0d tests run, %0d failed, %0d mismatches", n_vec, fail_tests, total_errs);
        if (n_vec > 0 && fail_tests == 0 && total_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* ex_stage_properties.sv */
`timescale 1ns/1ps

module ex_stage_properties import ex_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      flush,
    input logic      busy,
    input logic      held_valid,
    input id_ex_t    held,
    input logic      out_valid,
    input logic      out_ready,
    input ex_mem_t   out_data,
    input redirect_t redirect
);

    // a multiply in flight keeps its instruction
    assert property (@(posedge clk) disable iff (rst)
        (busy && !flush) |=> (held_valid && $stable(held)))
        else $error("held instruction changed while busy");

    // redirect only on the cycle the result leaves
    assert property (@(posedge clk) disable iff (rst)
        redirect.pc_update |-> (out_valid && out_ready))
        else $error("pc_update without an accepted result");

    // stalled output holds
    assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready && !flush) |=> $stable(out_data))
        else $error("out_data changed under back-pressure");

endmodule

bind ex_stage ex_stage_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .busy       (busy),
    .held_valid (held_valid),
    .held       (held),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .redirect   (redirect)
);

/* ex_stage.sv */
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  logic      in_valid,
    input  id_ex_t    in_instr,
    output logic      in_ready,
    input  fwd_t      mem_fwd,
    input  fwd_t      wb_fwd,
    output logic      out_valid,
    input  logic      out_ready,
    output ex_mem_t   out_data,
    output redirect_t redirect
);

    logic    held_valid;
    id_ex_t  held;
    xword_t  src1;
    xword_t  src2;
    xword_t  opnd_a;
    xword_t  opnd_b;
    alu_op_t alu_op;
    xword_t  alu_result;
    xword_t  alu_raw;
    logic    word_op;
    logic    word_rshift;
    logic    is_mul;
    logic    mul_start;
    logic    mul_clear;
    logic    mul_done;
    xword_t  mul_product;
    logic    busy;

    ex_issue_reg u_issue_reg (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .load       (in_ready),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .held_valid (held_valid),
        .held       (held)
    );

    operand_bypass u_bypass (
        .held    (held),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .src1    (src1),
        .src2    (src2),
        .opnd_a  (opnd_a),
        .opnd_b  (opnd_b),
        .alu_op  (alu_op)
    );

    assign word_op     = held.op_class inside {OPC_OP_IMM_W, OPC_OP_W};
    assign word_rshift = word_op && held.funct3 == 3'b101;

    alu_core u_alu (
        .alu_op      (alu_op),
        .opnd_a      (opnd_a),
        .opnd_b      (opnd_b),
        .word_op     (word_op),
        .word_rshift (word_rshift),
        .result      (alu_result),
        .raw         (alu_raw)
    );

    branch_resolve u_branch (
        .held_valid (held_valid),
        .held       (held),
        .src1       (src1),
        .src2       (src2),
        .alu_raw    (alu_raw),
        .out_ready  (out_ready),
        .redirect   (redirect)
    );

    // m-extension bit in imm[5], funct3 0..3 is the mul group
    assign is_mul = held.op_class inside {OPC_OP, OPC_OP_W} && held.imm[5] && !held.funct3[2];

    // kick off only when mem can take the result
    // once done, keep the request up under back-pressure so the result holds
    assign mul_start = held_valid && is_mul && (out_ready || mul_done);
    // result leaves this cycle, back to idle for the next multiply
    assign mul_clear = flush || (held_valid && mul_done && out_ready);

    shift_add_mul u_mul (
        .clk          (clk),
        .rst          (rst),
        .flush        (mul_clear),
        .start        (mul_start),
        .word         (held.op_class == OPC_OP_W),
        .multiplicand (src1),
        .multiplier   (src2),
        .done         (mul_done),
        .product      (mul_product)
    );

    // stall while a held multiply has no product yet
    assign busy      = held_valid && is_mul && !mul_done;
    assign in_ready  = busy ? 1'b0 : out_ready;
    assign out_valid = held_valid && !busy;

    always_comb begin
        out_data.pc         = held.pc;
        out_data.op_class   = held.op_class;
        out_data.funct3     = held.funct3;
        out_data.rd         = held.rd;
        out_data.rs2        = held.rs2;
        out_data.result     = is_mul ? mul_product : alu_result;
        // forwarded rs2 for stores
        out_data.store_data = src2;
    end

endmodule

/* shift_add_mul.sv */
`timescale 1ns/1ps
`include "ex_settings.svh"

module shift_add_mul import ex_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  logic   start,
    input  logic   word,
    input  xword_t multiplicand,
    input  xword_t multiplier,
    output logic   done,
    output xword_t product
);

    localparam int CNT_W = $clog2(`MUL_ITER_D + 1);

    mul_state_e       state;
    logic [CNT_W-1:0] cnt;
    // partial product and the shifting operands
    xword_t           acc;
    xword_t           mcand;
    xword_t           mplier;

    // control
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= MUL_IDLE;
            cnt   <= '0;
        end else begin
            unique case (state)
                MUL_IDLE: begin
                    if (start) begin
                        state <= MUL_RUN;
                        cnt   <= word ? CNT_W'(`MUL_ITER_W) : CNT_W'(`MUL_ITER_D);
                    end
                end
                MUL_RUN: begin
                    cnt <= cnt - 1'b1;
                    // last multiplier bit this cycle
                    if (cnt == CNT_W'(1)) begin
                        state <= MUL_DONE;
                    end
                end
                MUL_DONE: begin
                    // hold result until the request goes away
                    if (!start) begin
                        state <= MUL_IDLE;
                    end
                end
                default: state <= MUL_IDLE;
            endcase
        end
    end

    // datapath
    // low 64 bits only, so sign of the operands does not matter
    always_ff @(posedge clk) begin
        if (state == MUL_IDLE && start) begin
            acc    <= '0;
            mcand  <= multiplicand;
            mplier <= multiplier;
        end else if (state == MUL_RUN) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign done = state == MUL_DONE;

    // mulw keeps the low word, sign-extended
    assign product = word ? {{32{acc[31]}}, acc[31:0]} : acc;

endmodule

/* branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve import ex_pkg::*; (
    input  logic      held_valid,
    input  id_ex_t    held,
    input  xword_t    src1,
    input  xword_t    src2,
    input  xword_t    alu_raw,
    input  logic      out_ready,
    output redirect_t redirect
);

    logic   same_sign;
    logic   lt_s;
    logic   lt_u;
    logic   taken;
    logic   mispredict;
    logic   is_jalr;
    xword_t target;

    // alu_raw holds src1 - src2 for branches
    assign same_sign = src1[63] == src2[63];
    // sign of the difference only counts when the signs agree
    assign lt_s = (src1[63] && !src2[63]) || (alu_raw[63] && same_sign);
    assign lt_u = (!src1[63] && src2[63]) || (alu_raw[63] && same_sign);

    always_comb begin
        unique case (held.funct3)
            3'b000:  taken = alu_raw == '0;
            3'b001:  taken = alu_raw != '0;
            3'b100:  taken = lt_s;
            3'b101:  taken = !lt_s;
            3'b110:  taken = lt_u;
            3'b111:  taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

    // fetch guessed taken for backward offsets, imm[12] is the offset sign
    assign mispredict = taken != held.imm[12];
    assign is_jalr    = held.op_class == OPC_JALR;

    // jalr base is rs1, branches use pc
    assign target = (is_jalr ? src1 : held.pc) + held.imm;

    // one pulse, on the cycle the instruction leaves
    assign redirect.pc_update = held_valid && out_ready
                              && (is_jalr || (held.op_class == OPC_BRANCH && mispredict));

    // mispredicted backward branch falls through
    assign redirect.dnpc = (!is_jalr && held.imm[12]) ? held.pc + xword_t'(4) : target;

endmodule

/* alu_core.sv */
`timescale 1ns/1ps

module alu_core import ex_pkg::*; (
    input  alu_op_t alu_op,
    input  xword_t  opnd_a,
    input  xword_t  opnd_b,
    input  logic    word_op,
    input  logic    word_rshift,
    output xword_t  result,
    output xword_t  raw
);

    logic [5:0] shamt;

    // operand b is already masked for shifts
    assign shamt = opnd_b[5:0];

    // one-hot mode, add when nothing else is set
    always_comb begin
        if (alu_op[ALU_SUB]) begin
            raw = opnd_a - opnd_b;
        end else if (alu_op[ALU_SLT]) begin
            raw = xword_t'($signed(opnd_a) < $signed(opnd_b));
        end else if (alu_op[ALU_SLTU]) begin
            raw = xword_t'(opnd_a < opnd_b);
        end else if (alu_op[ALU_AND]) begin
            raw = opnd_a & opnd_b;
        end else if (alu_op[ALU_OR]) begin
            raw = opnd_a | opnd_b;
        end else if (alu_op[ALU_XOR]) begin
            raw = opnd_a ^ opnd_b;
        end else if (alu_op[ALU_SLL]) begin
            raw = opnd_a << shamt;
        end else if (alu_op[ALU_SRL]) begin
            raw = opnd_a >> shamt;
        end else if (alu_op[ALU_SRA]) begin
            raw = xword_t'($signed(opnd_a) >>> shamt);
        end else begin
            // ALU_ADD
            raw = opnd_a + opnd_b;
        end
    end

    // word ops
    // right shifts ran with rs1 in the upper half, so the answer sits in 63:32
    // and sra already filled from bit 31 of rs1
    // all other word ops keep 31:0
    always_comb begin
        if (word_rshift) begin
            result = {{32{raw[63]}}, raw[63:32]};
        end else if (word_op) begin
            result = {{32{raw[31]}}, raw[31:0]};
        end else begin
            result = raw;
        end
    end

endmodule

/* operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass import ex_pkg::*; (
    input  id_ex_t  held,
    input  fwd_t    mem_fwd,
    input  fwd_t    wb_fwd,
    output xword_t  src1,
    output xword_t  src2,
    output xword_t  opnd_a,
    output xword_t  opnd_b,
    output alu_op_t alu_op
);

    logic uses_rs2;
    logic is_shift;
    logic word_rshift;
    logic cls_i;
    logic cls_r;
    logic cls_iw;
    logic cls_rw;

    // newest value wins, mem is younger than wb
    // x0 is never forwarded
    function automatic xword_t resolve(reg_idx_t idx, xword_t regval, fwd_t mem, fwd_t wb);
        if (idx != '0 && mem.writing && mem.rd == idx) begin
            return mem.data;
        end else if (idx != '0 && wb.writing && wb.rd == idx) begin
            return wb.data;
        end
        return regval;
    endfunction

    // only these classes really read rs2
    assign uses_rs2 = held.op_class inside {OPC_BRANCH, OPC_STORE, OPC_OP, OPC_OP_W};

    assign src1 = resolve(held.rs1, held.src_a, mem_fwd, wb_fwd);
    assign src2 = uses_rs2 ? resolve(held.rs2, held.src_b, mem_fwd, wb_fwd) : held.src_b;

    assign cls_i  = held.op_class == OPC_OP_IMM;
    assign cls_r  = held.op_class == OPC_OP;
    assign cls_iw = held.op_class == OPC_OP_IMM_W;
    assign cls_rw = held.op_class == OPC_OP_W;

    assign is_shift    = held.funct3 inside {3'b001, 3'b101};
    // srlw/sraw/srliw/sraiw run in the upper half of the alu
    assign word_rshift = (cls_iw || cls_rw) && held.funct3 == 3'b101;

    // operand a
    always_comb begin
        if (held.op_class == OPC_LUI) begin
            opnd_a = '0;
        end else if (held.op_class inside {OPC_AUIPC, OPC_JAL, OPC_JALR}) begin
            opnd_a = held.pc;
        end else if (word_rshift) begin
            opnd_a = {src1[31:0], 32'b0};
        end else begin
            opnd_a = src1;
        end
    end

    // operand b, shift amounts masked to 6 or 5 bits
    always_comb begin
        unique case (held.op_class)
            // link value pc+4
            OPC_JAL, OPC_JALR:  opnd_b = xword_t'(4);
            OPC_OP:             opnd_b = is_shift ? xword_t'(src2[5:0]) : src2;
            OPC_OP_W:           opnd_b = is_shift ? xword_t'(src2[4:0]) : src2;
            OPC_OP_IMM:         opnd_b = is_shift ? xword_t'(held.imm[5:0]) : held.imm;
            OPC_OP_IMM_W:       opnd_b = is_shift ? xword_t'(held.imm[4:0]) : held.imm;
            OPC_LUI, OPC_AUIPC,
            OPC_LOAD, OPC_STORE: opnd_b = held.imm;
            default:            opnd_b = src2;
        endcase
    end

    // alu mode
    // branches subtract, add is the fallback for everything else
    always_comb begin
        alu_op           = '0;
        alu_op[ALU_SUB]  = (held.op_class == OPC_BRANCH)
                         || ((cls_r || cls_rw) && held.funct3 == 3'b000 && held.imm[10]);
        alu_op[ALU_SLT]  = (cls_i || cls_r) && held.funct3 == 3'b010;
        alu_op[ALU_SLTU] = (cls_i || cls_r) && held.funct3 == 3'b011;
        alu_op[ALU_AND]  = (cls_i || cls_r) && held.funct3 == 3'b111;
        alu_op[ALU_OR]   = (cls_i || cls_r) && held.funct3 == 3'b110;
        alu_op[ALU_XOR]  = (cls_i || cls_r) && held.funct3 == 3'b100;
        alu_op[ALU_SLL]  = (cls_i || cls_r || cls_iw || cls_rw) && held.funct3 == 3'b001;
        // imm[10] separates arithmetic from logical right shift
        alu_op[ALU_SRL]  = (cls_i || cls_r || cls_iw || cls_rw) && held.funct3 == 3'b101
                         && !held.imm[10];
        alu_op[ALU_SRA]  = (cls_i || cls_r || cls_iw || cls_rw) && held.funct3 == 3'b101
                         && held.imm[10];
        alu_op[ALU_ADD]  = ~|alu_op;
    end

endmodule

/* ex_issue_reg.sv */
`timescale 1ns/1ps

module ex_issue_reg import ex_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  logic   load,
    input  logic   in_valid,
    input  id_ex_t in_instr,
    output logic   held_valid,
    output id_ex_t held
);

    // valid bit
    // flush kills whatever sits here, wrong-path instruction
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            held_valid <= 1'b0;
        end else if (load) begin
            held_valid <= in_valid;
        end
    end

    // instruction payload
    // only meaningful while held_valid is set
    always_ff @(posedge clk) begin
        if (load) begin
            held <= in_instr;
        end
    end

endmodule

/* ex_pkg.sv */
`include "ex_settings.svh"

package ex_pkg;

    // data and address word
    typedef logic [`XLEN-1:0] xword_t;
    // register index
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    // funct3 field of the instruction
    typedef logic [2:0] funct3_t;
    // one-hot alu mode, see bit positions below
    typedef logic [9:0] alu_op_t;

    // alu mode bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_OR   = 5;
    localparam int ALU_XOR  = 6;
    localparam int ALU_SLL  = 7;
    localparam int ALU_SRL  = 8;
    localparam int ALU_SRA  = 9;

    // instruction class, set by decode
    typedef enum logic [3:0] {
        OPC_LUI,
        OPC_AUIPC,
        OPC_JAL,
        OPC_JALR,
        OPC_BRANCH,
        OPC_LOAD,
        OPC_STORE,
        OPC_OP_IMM,
        OPC_OP,
        OPC_OP_IMM_W,
        OPC_OP_W
    } op_class_e;

    // multiplier fsm
    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_e;

    // instruction issued from decode into ex
    typedef struct packed {
        xword_t    pc;
        op_class_e op_class;
        funct3_t   funct3;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        // register file read data, may be stale
        xword_t    src_a;
        xword_t    src_b;
        // r-type carries imm_i here, so imm[10] and imm[5] hold funct7 bits
        xword_t    imm;
    } id_ex_t;

    // one bypass source from a later stage
    typedef struct packed {
        logic     writing;
        reg_idx_t rd;
        xword_t   data;
    } fwd_t;

    // ex result toward mem
    typedef struct packed {
        xword_t    pc;
        op_class_e op_class;
        funct3_t   funct3;
        reg_idx_t  rd;
        reg_idx_t  rs2;
        xword_t    result;
        xword_t    store_data;
    } ex_mem_t;

    // fetch redirect on mispredict or jalr
    typedef struct packed {
        logic   pc_update;
        xword_t dnpc;
    } redirect_t;

endpackage

/* ex_settings.svh */
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// datapath width of the integer core
`define XLEN 64

// architectural register index, x0..x31
`define REG_IDX_W 5

// multiplier iterations, one multiplier bit per cycle
// full mul walks all 64 bits
`define MUL_ITER_D 64
// mulw only needs the low half of the multiplier
`define MUL_ITER_W 32

`endif
